/* include/ldpc_qc_dec_config.svh */
// fixed code only: 2x4 base matrix, all circulants present, lifting 8, shifts packed 3 bits each
`ifndef LDPC_QC_DEC_CONFIG_SVH
`define LDPC_QC_DEC_CONFIG_SVH

// ------------------------------
// code geometry
// ------------------------------
`define LDPC_ZC         8   // lifting size
`define LDPC_ROWS       2   // base rows
`define LDPC_COLS       4   // base columns
`define LDPC_INFO_COLS  2   // systematic columns 0 and 1

// ------------------------------
// interface widths
// ------------------------------
`define LDPC_LLR_W      8   // signed llr
`define LDPC_LLR_NUM    4   // llrs per input beat
`define LDPC_DAT_W      8   // output beat
`define LDPC_TAG_W      4
`define LDPC_NITER_W    8   // iteration limit and count
`define LDPC_ERR_W      8   // corrected info bits

// ------------------------------
// circulant shifts, column 0 in the low field
// ------------------------------
// row 0 : 0 1 2 3
`define LDPC_SHIFT_R0   12'h688
// row 1 : 0 3 5 7
`define LDPC_SHIFT_R1   12'hF58

`endif

/* rtl/ldpc_qc_dec_pkg.sv */
// parity functions assume every base entry present and shift fields of log2(lifting) bits
`include "ldpc_qc_dec_config.svh"

package ldpc_qc_dec_pkg;

  // ------------------------------
  // derived sizes
  // ------------------------------
  localparam int code_n     = `LDPC_COLS * `LDPC_ZC;       // 32
  localparam int info_k     = `LDPC_INFO_COLS * `LDPC_ZC;  // 16
  localparam int check_m    = `LDPC_ROWS * `LDPC_ZC;       // 16
  localparam int in_beats   = code_n / `LDPC_LLR_NUM;      // 8
  localparam int out_beats  = info_k / `LDPC_DAT_W;        // 2
  // {fmode, niter, tag, hard bits}
  localparam int in_word_w  = 1 + `LDPC_NITER_W + `LDPC_TAG_W + code_n;
  // {decfail, err, uniter, tag, info bits}
  localparam int out_word_w = 1 + `LDPC_ERR_W + `LDPC_NITER_W + `LDPC_TAG_W + info_k;

  localparam int shift_w    = $clog2(`LDPC_ZC);
  localparam logic [`LDPC_ROWS-1:0][`LDPC_COLS*shift_w-1:0] shift_tab =
    {`LDPC_SHIFT_R1, `LDPC_SHIFT_R0};

  // check r*zc+j sums bit c*zc+((j+shift) mod zc) over all columns
  function automatic logic [check_m-1:0] check_syndrome(input logic [code_n-1:0] bits);
    logic [check_m-1:0] syn;
    int sh;
    syn = '0;
    for (int r = 0; r < `LDPC_ROWS; r++) begin
      for (int j = 0; j < `LDPC_ZC; j++) begin
        for (int c = 0; c < `LDPC_COLS; c++) begin
          sh = int'(shift_tab[r][c*shift_w +: shift_w]);
          syn[r*`LDPC_ZC + j] ^= bits[c*`LDPC_ZC + (j + sh) % `LDPC_ZC];
        end
      end
    end
    return syn;
  endfunction

  // a bit is flagged only when every check it sits in fails
  function automatic logic [code_n-1:0] unsat_per_bit(input logic [code_n-1:0] bits);
    logic [check_m-1:0] syn;
    logic [code_n-1:0]  flag;
    int sh;
    syn  = check_syndrome(bits);
    flag = '1;
    for (int c = 0; c < `LDPC_COLS; c++) begin
      for (int k = 0; k < `LDPC_ZC; k++) begin
        for (int r = 0; r < `LDPC_ROWS; r++) begin
          sh = int'(shift_tab[r][c*shift_w +: shift_w]);
          flag[c*`LDPC_ZC + k] &= syn[r*`LDPC_ZC + (k - sh + `LDPC_ZC) % `LDPC_ZC];
        end
      end
    end
    return flag;
  endfunction

  // negative llr -> bit 1
  function automatic logic hard_bit(input logic signed [`LDPC_LLR_W-1:0] llr);
    return llr[`LDPC_LLR_W-1];
  endfunction

endpackage

/* rtl/ldpc_qc_dec_source.sv */
// frames must be exactly 8 beats framed by sop/eop; no beat count check, only llr signs are kept
`timescale 1ns/1ps
`include "ldpc_qc_dec_config.svh"

module ldpc_qc_dec_source
  import ldpc_qc_dec_pkg::*;
(
  input  logic                                         iclk,
  input  logic                                         rst_n,
  input  logic                                         ival,
  input  logic                                         isop,
  input  logic                                         ieop,
  input  logic [`LDPC_TAG_W-1:0]                       itag,
  input  logic [`LDPC_NITER_W-1:0]                     initer,
  input  logic                                         ifmode,
  input  logic [`LDPC_LLR_NUM-1:0][`LDPC_LLR_W-1:0]    illr,
  input  logic                                         has_free,
  output logic                                         ordy,
  output logic                                         commit,
  output logic [in_word_w-1:0]                         word
);

  logic                     frame_done;  // full frame held, waiting for a bank
  logic                     in_frame;    // between accepted sop and eop
  logic                     take;
  logic [`LDPC_LLR_NUM-1:0] beat_bits;
  logic [code_n-1:0]        hard_r;
  logic [`LDPC_TAG_W-1:0]   tag_r;
  logic [`LDPC_NITER_W-1:0] niter_r;
  logic                     fmode_r;

  // ------------------------------
  // handshake
  // ------------------------------
  assign ordy   = !frame_done;           // stall input while frame waits
  assign take   = ival && ordy;
  assign commit = frame_done && has_free;

  always_comb begin
    for (int i = 0; i < `LDPC_LLR_NUM; i++) begin
      beat_bits[i] = hard_bit(illr[i]);
    end
  end

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      frame_done <= 1'b0;
      in_frame   <= 1'b0;
    end else begin
      if (take && ieop) begin
        frame_done <= 1'b1;
        in_frame   <= 1'b0;
      end else if (take && isop) begin
        in_frame <= 1'b1;
      end
      if (commit) frame_done <= 1'b0;  // eop can't be taken here, ordy is low
    end
  end

  // ------------------------------
  // payload, no reset
  // ------------------------------
  always_ff @(posedge iclk) begin
    if (take) begin
      hard_r <= {beat_bits, hard_r[code_n-1:`LDPC_LLR_NUM]};  // beat 0 ends at lsb
      if (isop) begin
        tag_r   <= itag;
        niter_r <= initer;
        fmode_r <= ifmode;
      end
    end
  end

  assign word = {fmode_r, niter_r, tag_r, hard_r};

  // first beat taken after an eop must open a new frame
  a_sop_after_eop : assert property (
    @(posedge iclk) disable iff (!rst_n)
    (take && !in_frame) |-> isop
  );

endmodule

/* rtl/ldpc_qc_dec_pingpong.sv */
// writer commits only while has_free, reader releases only while has_frame; frames leave in order
`timescale 1ns/1ps
`include "ldpc_qc_dec_config.svh"

module ldpc_qc_dec_pingpong #(
  parameter int word_w = 45
) (
  input  logic              iclk,
  input  logic              rst_n,
  input  logic              commit,
  input  logic [word_w-1:0] wword,
  input  logic              release_bank,
  output logic [word_w-1:0] rword,
  output logic              has_frame,
  output logic              has_free
);

  logic [word_w-1:0] bank [2];   // frame storage
  logic              wr_ptr;
  logic              rd_ptr;
  logic [1:0]        vld;        // one valid flag per bank

  // banks are used strictly in turn so the free one is always under wr_ptr
  assign has_free  = !vld[wr_ptr];
  assign has_frame = vld[rd_ptr];
  assign rword     = bank[rd_ptr];

  // ------------------------------
  // pointers and flags
  // ------------------------------
  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      vld    <= '0;
    end else begin
      if (commit) begin
        vld[wr_ptr] <= 1'b1;
        wr_ptr      <= !wr_ptr;
      end
      if (release_bank) begin
        vld[rd_ptr] <= 1'b0;   // never the bank being committed
        rd_ptr      <= !rd_ptr;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (commit) bank[wr_ptr] <= wword;
  end

  a_no_overflow : assert property (
    @(posedge iclk) disable iff (!rst_n) commit |-> has_free
  );

  a_no_underflow : assert property (
    @(posedge iclk) disable iff (!rst_n) release_bank |-> has_frame
  );

endmodule

/* rtl/ldpc_qc_dec_engine.sv */
// hard-decision bit flipping, one iteration per cycle; niter 0 passes the input decisions through
`timescale 1ns/1ps
`include "ldpc_qc_dec_config.svh"

module ldpc_qc_dec_engine
  import ldpc_qc_dec_pkg::*;
(
  input  logic                  iclk,
  input  logic                  rst_n,
  input  logic                  in_has_frame,
  input  logic [in_word_w-1:0]  in_word,
  output logic                  in_release,
  input  logic                  out_has_free,
  output logic                  out_commit,
  output logic [out_word_w-1:0] out_word,
  output logic                  busy
);

  // input word fields
  logic                     in_fmode;
  logic [`LDPC_NITER_W-1:0] in_niter;
  logic [`LDPC_TAG_W-1:0]   in_tag;
  logic [code_n-1:0]        in_hard;

  // frame being decoded
  logic                     run;
  logic [`LDPC_NITER_W-1:0] iter;      // iterations done so far
  logic [code_n-1:0]        bits;      // current decisions
  logic [info_k-1:0]        orig;      // input decisions of info bits
  logic [`LDPC_NITER_W-1:0] niter_r;
  logic                     fmode_r;
  logic [`LDPC_TAG_W-1:0]   tag_r;

  logic                     start;
  logic                     stop;
  logic [check_m-1:0]       syn;
  logic [info_k-1:0]        diff;
  logic [`LDPC_ERR_W-1:0]   err_cnt;

  assign {in_fmode, in_niter, in_tag, in_hard} = in_word;

  // ------------------------------
  // control
  // ------------------------------
  // out bank stays free until commit, only this block fills it
  assign start      = !run && in_has_frame && out_has_free;
  assign in_release = start;                       // word copied this cycle
  assign busy       = run;

  assign syn  = check_syndrome(bits);              // checked before each iteration
  assign stop = (iter == niter_r) || (fmode_r && (syn == '0));

  assign out_commit = run && stop;                 // cycle after last flip

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      run  <= 1'b0;
      iter <= '0;
    end else begin
      if (start) begin
        run  <= 1'b1;
        iter <= '0;
      end else if (run) begin
        if (stop) begin
          run <= 1'b0;
        end else begin
          iter <= iter + 1'b1;
        end
      end
    end
  end

  // ------------------------------
  // datapath
  // ------------------------------
  always_ff @(posedge iclk) begin
    if (start) begin
      bits    <= in_hard;
      orig    <= in_hard[info_k-1:0];
      niter_r <= in_niter;
      fmode_r <= in_fmode;
      tag_r   <= in_tag;
    end else if (run && !stop) begin
      bits <= bits ^ unsat_per_bit(bits);          // flip where all checks fail
    end
  end

  // corrected info bits
  assign diff = bits[info_k-1:0] ^ orig;

  always_comb begin
    err_cnt = '0;
    for (int i = 0; i < info_k; i++) begin
      err_cnt = err_cnt + `LDPC_ERR_W'(diff[i]);
    end
  end

  // {decfail, err, uniter, tag, info}
  assign out_word = {|syn, err_cnt, iter, tag_r, bits[info_k-1:0]};

  a_iter_bound : assert property (
    @(posedge iclk) disable iff (!rst_n) run |-> (iter <= niter_r)
  );

endmodule

/* rtl/ldpc_qc_dec_sink.sv */
// outputs are registered, so a beat shows one clock after the ireq cycle that issued it
`timescale 1ns/1ps
`include "ldpc_qc_dec_config.svh"

module ldpc_qc_dec_sink
  import ldpc_qc_dec_pkg::*;
(
  input  logic                     iclk,
  input  logic                     rst_n,
  input  logic                     has_frame,
  input  logic [out_word_w-1:0]    word,
  input  logic                     ireq,
  output logic                     release_bank,
  output logic                     ofull,
  output logic                     oval,
  output logic                     osop,
  output logic                     oeop,
  output logic [`LDPC_DAT_W-1:0]   odat,
  output logic [`LDPC_TAG_W-1:0]   otag,
  output logic                     odecfail,
  output logic [`LDPC_ERR_W-1:0]   oerr,
  output logic [`LDPC_NITER_W-1:0] ouniter
);

  localparam int beat_w = (out_beats > 1) ? $clog2(out_beats) : 1;

  logic                     w_decfail;
  logic [`LDPC_ERR_W-1:0]   w_err;
  logic [`LDPC_NITER_W-1:0] w_uniter;
  logic [`LDPC_TAG_W-1:0]   w_tag;
  logic [info_k-1:0]        w_info;

  logic              issue;
  logic              last;
  logic [beat_w-1:0] beat;   // next beat index within frame

  assign {w_decfail, w_err, w_uniter, w_tag, w_info} = word;

  assign ofull        = has_frame;
  assign issue        = ireq && has_frame;
  assign last         = (beat == beat_w'(out_beats - 1));
  assign release_bank = issue && last;   // bank freed with eop beat

  // ------------------------------
  // framing
  // ------------------------------
  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      oval <= 1'b0;
      osop <= 1'b0;
      oeop <= 1'b0;
      beat <= '0;
    end else begin
      oval <= issue;
      osop <= issue && (beat == '0);
      oeop <= issue && last;
      if (issue) beat <= last ? '0 : beat + 1'b1;   // ireq low holds mid-frame
    end
  end

  // data and status, held between beats
  always_ff @(posedge iclk) begin
    if (issue) begin
      odat     <= w_info[beat*`LDPC_DAT_W +: `LDPC_DAT_W];  // lsb = lowest bit index
      otag     <= w_tag;
      odecfail <= w_decfail;
      oerr     <= w_err;
      ouniter  <= w_uniter;
    end
  end

  // bank stays held until its eop beat is issued
  a_frame_held : assert property (
    @(posedge iclk) disable iff (!rst_n) (beat != '0) |-> has_frame
  );

endmodule

/* rtl/ldpc_qc_dec.sv */
// fixed-code decoder top; up to two frames queue on each side of the engine, output paced by ireq
`timescale 1ns/1ps
`include "ldpc_qc_dec_config.svh"

module ldpc_qc_dec
  import ldpc_qc_dec_pkg::*;
(
  input  logic                                      iclk,
  input  logic                                      rst_n,
  input  logic                                      ival,
  input  logic                                      isop,
  input  logic                                      ieop,
  input  logic [`LDPC_TAG_W-1:0]                    itag,
  input  logic [`LDPC_NITER_W-1:0]                  initer,
  input  logic                                      ifmode,
  input  logic [`LDPC_LLR_NUM-1:0][`LDPC_LLR_W-1:0] illr,
  output logic                                      ordy,
  output logic                                      obusy,
  input  logic                                      ireq,
  output logic                                      ofull,
  output logic                                      oval,
  output logic                                      osop,
  output logic                                      oeop,
  output logic [`LDPC_DAT_W-1:0]                    odat,
  output logic [`LDPC_TAG_W-1:0]                    otag,
  output logic                                      odecfail,
  output logic [`LDPC_ERR_W-1:0]                    oerr,
  output logic [`LDPC_NITER_W-1:0]                  ouniter
);

  // source -> ibuf -> engine
  logic                  src_commit;
  logic [in_word_w-1:0]  src_word;
  logic                  ibuf_has_free;
  logic                  ibuf_has_frame;
  logic [in_word_w-1:0]  ibuf_rword;
  logic                  eng_release;
  // engine -> obuf -> sink
  logic                  eng_commit;
  logic [out_word_w-1:0] eng_word;
  logic                  eng_busy;
  logic                  obuf_has_free;
  logic                  obuf_has_frame;
  logic [out_word_w-1:0] obuf_rword;
  logic                  sink_release;

  ldpc_qc_dec_source i_source (
    .iclk, .rst_n, .ival, .isop, .ieop, .itag, .initer, .ifmode, .illr,
    .has_free (ibuf_has_free),
    .ordy,
    .commit   (src_commit),
    .word     (src_word)
  );

  ldpc_qc_dec_pingpong #(.word_w(in_word_w)) i_ibuf (
    .iclk, .rst_n,
    .commit       (src_commit),
    .wword        (src_word),
    .release_bank (eng_release),
    .rword        (ibuf_rword),
    .has_frame    (ibuf_has_frame),
    .has_free     (ibuf_has_free)
  );

  ldpc_qc_dec_engine i_engine (
    .iclk, .rst_n,
    .in_has_frame (ibuf_has_frame),
    .in_word      (ibuf_rword),
    .in_release   (eng_release),
    .out_has_free (obuf_has_free),
    .out_commit   (eng_commit),
    .out_word     (eng_word),
    .busy         (eng_busy)
  );

  ldpc_qc_dec_pingpong #(.word_w(out_word_w)) i_obuf (
    .iclk, .rst_n,
    .commit       (eng_commit),
    .wword        (eng_word),
    .release_bank (sink_release),
    .rword        (obuf_rword),
    .has_frame    (obuf_has_frame),
    .has_free     (obuf_has_free)
  );

  ldpc_qc_dec_sink i_sink (
    .iclk, .rst_n,
    .has_frame    (obuf_has_frame),
    .word         (obuf_rword),
    .ireq,
    .release_bank (sink_release),
    .ofull, .oval, .osop, .oeop, .odat, .otag, .odecfail, .oerr, .ouniter
  );

  assign obusy = ibuf_has_frame || eng_busy;   // queued or decoding

endmodule

/* dv/ldpc_qc_dec_tb.sv */
// one frame driven at a time, ireq randomized with long stalls; the model repeats the flip rule itself
`timescale 1ns/1ps
`include "ldpc_qc_dec_config.svh"

module ldpc_qc_dec_tb;

  localparam int zc        = `LDPC_ZC;
  localparam int n_bits    = `LDPC_COLS * zc;              // code bits
  localparam int k_bits    = `LDPC_INFO_COLS * zc;         // info bits
  localparam int m_chk     = `LDPC_ROWS * zc;              // checks
  localparam int n_beats   = n_bits / `LDPC_LLR_NUM;
  localparam int o_beats   = k_bits / `LDPC_DAT_W;
  localparam int n_frames  = 200;
  localparam int beat_tmo  = 4000;                         // cycles
  localparam int drain_tmo = 20000;

  // circulant shifts, [row][column]
  int shifts [`LDPC_ROWS][`LDPC_COLS] = '{'{0, 1, 2, 3}, '{0, 3, 5, 7}};

  logic                                      iclk;
  logic                                      rst_n;
  logic                                      ival;
  logic                                      isop;
  logic                                      ieop;
  logic [`LDPC_TAG_W-1:0]                    itag;
  logic [`LDPC_NITER_W-1:0]                  initer;
  logic                                      ifmode;
  logic [`LDPC_LLR_NUM-1:0][`LDPC_LLR_W-1:0] illr;
  logic                                      ordy;
  logic                                      obusy;
  logic                                      ireq;
  logic                                      ofull;
  logic                                      oval;
  logic                                      osop;
  logic                                      oeop;
  logic [`LDPC_DAT_W-1:0]                    odat;
  logic [`LDPC_TAG_W-1:0]                    otag;
  logic                                      odecfail;
  logic [`LDPC_ERR_W-1:0]                    oerr;
  logic [`LDPC_NITER_W-1:0]                  ouniter;

  // expected results, oldest frame first
  logic [`LDPC_TAG_W-1:0]   q_tag   [$];
  logic                     q_fail  [$];
  logic [`LDPC_ERR_W-1:0]   q_err   [$];
  logic [`LDPC_NITER_W-1:0] q_iter  [$];
  logic [k_bits-1:0]        q_info  [$];
  logic                     q_clean [$];   // zero codeword, no sign errors
  logic                     q_fmode [$];
  logic [`LDPC_NITER_W-1:0] q_niter [$];

  int frames_out;
  int beat_idx;                            // next output beat in frame
  int req_hold;                            // cycles left in a long ireq-low stall
  bit seen_stall;

  ldpc_qc_dec i_dut (
    .iclk, .rst_n, .ival, .isop, .ieop, .itag, .initer, .ifmode, .illr,
    .ordy, .obusy, .ireq, .ofull, .oval, .osop, .oeop, .odat, .otag,
    .odecfail, .oerr, .ouniter
  );

  always #50 iclk = ~iclk;

  // ------------------------------
  // error handling
  // ------------------------------
  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL time %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // ------------------------------
  // reference model
  // ------------------------------
  // check r*zc+j covers bit c*zc+((j+shift) mod zc)
  function automatic logic [m_chk-1:0] parity_checks(input logic [n_bits-1:0] b);
    logic [m_chk-1:0] s;
    s = '0;
    for (int r = 0; r < `LDPC_ROWS; r++)
      for (int j = 0; j < zc; j++)
        for (int c = 0; c < `LDPC_COLS; c++)
          s[r*zc + j] = s[r*zc + j] ^ b[c*zc + (j + shifts[r][c]) % zc];
    return s;
  endfunction

  // count failed checks per bit, flip where all of them fail
  function automatic logic [n_bits-1:0] flip_mask(input logic [n_bits-1:0] b);
    logic [m_chk-1:0]  s;
    int                fails [n_bits];
    logic [n_bits-1:0] m;
    s = parity_checks(b);
    foreach (fails[i]) fails[i] = 0;
    for (int r = 0; r < `LDPC_ROWS; r++)
      for (int j = 0; j < zc; j++)
        for (int c = 0; c < `LDPC_COLS; c++)
          if (s[r*zc + j]) fails[c*zc + (j + shifts[r][c]) % zc]++;
    for (int i = 0; i < n_bits; i++) m[i] = (fails[i] == `LDPC_ROWS);
    return m;
  endfunction

  task automatic model_push(input logic [n_bits-1:0] hard, input logic [`LDPC_NITER_W-1:0] niter,
                            input logic fmode, input logic [`LDPC_TAG_W-1:0] tag,
                            input logic clean);
    logic [n_bits-1:0] b;
    logic [m_chk-1:0]  s;
    int                it;
    int                nerr;
    b  = hard;
    it = 0;
    s  = parity_checks(b);
    while (it < int'(niter) && !(fmode && s == '0)) begin   // early stop only in fast mode
      b = b ^ flip_mask(b);
      it++;
      s = parity_checks(b);
    end
    nerr = 0;
    for (int i = 0; i < k_bits; i++) if (b[i] != hard[i]) nerr++;
    q_tag.push_back(tag);
    q_fail.push_back(s != '0);
    q_err.push_back(nerr);
    q_iter.push_back(it);
    q_info.push_back(b[k_bits-1:0]);
    q_clean.push_back(clean);
    q_fmode.push_back(fmode);
    q_niter.push_back(niter);
  endtask

  // ------------------------------
  // input driver
  // ------------------------------
  task automatic wait_ordy();
    int cyc;
    cyc = 0;
    while (!ordy) begin
      @(negedge iclk);
      cyc++;
      if (!ordy) seen_stall = 1'b1;        // held past the commit cycle, buffers full
      if (cyc > beat_tmo) begin
        $display("timeout: ordy stayed low while an input beat was waiting");
        abort_run();
      end
    end
  endtask

  task automatic send_frame(input int idx);
    logic [`LDPC_LLR_W-1:0]   llr [n_bits];
    logic [n_bits-1:0]        hard;
    logic [`LDPC_TAG_W-1:0]   tag;
    logic [`LDPC_NITER_W-1:0] niter;
    logic                     fmode;
    logic                     cword;
    int                       nneg;
    tag   = $urandom_range(2**`LDPC_TAG_W - 1, 0);
    niter = $urandom_range(12, 0);
    fmode = $urandom_range(1, 0);
    cword = (idx < 4) || ($urandom_range(1, 0) == 1);
    nneg  = 0;
    if (idx < 4) begin
      fmode = idx[0];                      // clean codeword in both modes first
      niter = $urandom_range(12, 1);
    end
    for (int i = 0; i < n_bits; i++) begin
      llr[i] = cword ? $urandom_range(127, 1) : $urandom_range(255, 0);
    end
    if (cword && idx >= 4) begin
      nneg = $urandom_range(3, 0);
      repeat (nneg) llr[$urandom_range(n_bits - 1, 0)] = 8'h80 | $urandom_range(127, 0);
    end
    for (int i = 0; i < n_bits; i++) hard[i] = llr[i][`LDPC_LLR_W-1];   // sign
    model_push(hard, niter, fmode, tag, cword && (nneg == 0));
    for (int b = 0; b < n_beats; b++) begin
      if ($urandom_range(7, 0) == 0) begin
        ival = 1'b0;                       // random idle gap
        repeat ($urandom_range(3, 1)) @(negedge iclk);
      end
      ival   = 1'b1;
      isop   = (b == 0);
      ieop   = (b == n_beats - 1);
      itag   = (b == 0) ? tag : $urandom_range(15, 0);   // junk off sop
      initer = (b == 0) ? niter : $urandom_range(255, 0);
      ifmode = (b == 0) ? fmode : $urandom_range(1, 0);
      for (int i = 0; i < `LDPC_LLR_NUM; i++) illr[i] = llr[b*`LDPC_LLR_NUM + i];
      wait_ordy();                         // ordy only moves on posedge
      @(negedge iclk);
    end
    ival = 1'b0;
    isop = 1'b0;
    ieop = 1'b0;
  endtask

  // ------------------------------
  // output monitor
  // ------------------------------
  task automatic check_beat();
    logic [k_bits-1:0] info;
    if (q_tag.size() == 0) begin
      $display("output beat seen with no frame outstanding");
      abort_run();
    end
    info = q_info[0];
    check_val("osop", osop, beat_idx == 0);
    check_val("oeop", oeop, beat_idx == o_beats - 1);
    check_val("odat", odat, info[beat_idx*`LDPC_DAT_W +: `LDPC_DAT_W]);
    check_val("otag", otag, q_tag[0]);
    check_val("odecfail", odecfail, q_fail[0]);
    check_val("oerr", oerr, q_err[0]);
    check_val("ouniter", ouniter, q_iter[0]);
    if (q_clean[0] && q_fmode[0]) begin     // valid codeword stops at once
      check_val("ouniter", ouniter, 0);
      check_val("odecfail", odecfail, 0);
      check_val("oerr", oerr, 0);
    end
    if (!q_fmode[0]) check_val("ouniter", ouniter, q_niter[0]);
    if (beat_idx == o_beats - 1) begin
      void'(q_tag.pop_front());
      void'(q_fail.pop_front());
      void'(q_err.pop_front());
      void'(q_iter.pop_front());
      void'(q_info.pop_front());
      void'(q_clean.pop_front());
      void'(q_fmode.pop_front());
      void'(q_niter.pop_front());
      beat_idx = 0;
      frames_out++;
    end else begin
      beat_idx++;
    end
  endtask

  always @(negedge iclk) begin
    if (rst_n && oval) check_beat();
  end

  // ireq: mostly random, sometimes held low long enough to back up the whole pipe
  always @(negedge iclk) begin
    if (req_hold > 0) begin
      req_hold--;
      ireq = 1'b0;
    end else if ($urandom_range(99, 0) < 2) begin
      req_hold = $urandom_range(150, 60);
      ireq     = 1'b0;
    end else begin
      ireq = ($urandom_range(3, 0) != 0);
    end
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int cyc;
    void'($urandom(30));
    iclk       = 1'b0;
    rst_n      = 1'b0;
    ival       = 1'b0;
    isop       = 1'b0;
    ieop       = 1'b0;
    itag       = '0;
    initer     = '0;
    ifmode     = 1'b0;
    illr       = '0;
    ireq       = 1'b0;
    req_hold   = 0;
    beat_idx   = 0;
    frames_out = 0;
    seen_stall = 1'b0;
    repeat (8) @(negedge iclk);
    rst_n = 1'b1;
    @(negedge iclk);
    check_val("ordy", ordy, 1);            // idle state after reset
    check_val("oval", oval, 0);
    check_val("ofull", ofull, 0);
    check_val("obusy", obusy, 0);
    for (int f = 0; f < n_frames; f++) send_frame(f);
    cyc = 0;
    while (frames_out < n_frames) begin
      @(negedge iclk);
      cyc++;
      if (cyc > drain_tmo) begin
        $display("timeout: only %0d of %0d frames came out", frames_out, n_frames);
        abort_run();
      end
    end
    assert (seen_stall) else begin
      $display("ordy was never held low, the buffers never filled");
      abort_run();
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* ldpc_qc_dec.f */
+incdir+include
rtl/ldpc_qc_dec_pkg.sv
rtl/ldpc_qc_dec_source.sv
rtl/ldpc_qc_dec_pingpong.sv
rtl/ldpc_qc_dec_engine.sv
rtl/ldpc_qc_dec_sink.sv
rtl/ldpc_qc_dec.sv
dv/ldpc_qc_dec_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ldpc_qc_dec testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f ldpc_qc_dec.f --top-module ldpc_qc_dec_tb -o ldpc_qc_dec_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/ldpc_qc_dec_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "simulation failed"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0
